// File: hdl/decode_pkg.sv
// Shared widths, opcodes, micro-op codes and instruction formats, imported by the decode stage
package decode_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      fu_t;
    typedef logic [4:0]      uop_t;

    // -------------------------------------------------------------------------
    // Functional units and micro-ops
    // -------------------------------------------------------------------------

    localparam int FU_ALU = 0;
    localparam int FU_LSU = 1;
    localparam int FU_CFU = 2;

    localparam uop_t ALU_ADD  = 5'd1;
    localparam uop_t ALU_SUB  = 5'd2;
    localparam uop_t ALU_AND  = 5'd3;
    localparam uop_t ALU_OR   = 5'd4;
    localparam uop_t ALU_XOR  = 5'd5;
    localparam uop_t ALU_SLT  = 5'd6;
    localparam uop_t ALU_SLTU = 5'd7;
    localparam uop_t ALU_SRA  = 5'd8;
    localparam uop_t ALU_SRL  = 5'd9;
    localparam uop_t ALU_SLL  = 5'd10;

    // LSU micro-op is a bit field, not an enumeration
    localparam int LSU_SIGNED    = 0;
    localparam int LSU_WIDTH_LSB = 1;  // Two-bit width field at [2:1]
    localparam int LSU_LOAD      = 3;
    localparam int LSU_STORE     = 4;

    localparam logic [1:0] LSU_BYTE = 2'b01;
    localparam logic [1:0] LSU_HALF = 2'b10;
    localparam logic [1:0] LSU_WORD = 2'b11;

    localparam uop_t CFU_BEQ    = 5'd1;
    localparam uop_t CFU_BNE    = 5'd2;
    localparam uop_t CFU_BLT    = 5'd3;
    localparam uop_t CFU_BGE    = 5'd4;
    localparam uop_t CFU_BLTU   = 5'd5;
    localparam uop_t CFU_BGEU   = 5'd6;
    localparam uop_t CFU_JALI   = 5'd7;
    localparam uop_t CFU_JALR   = 5'd8;
    localparam uop_t CFU_ECALL  = 5'd9;
    localparam uop_t CFU_EBREAK = 5'd10;

    typedef struct packed {
        logic opra_rs1;   // A from rs1
        logic opra_pcim;  // A from PC plus immediate
        logic oprb_rs2;   // B from rs2
        logic oprb_imm;   // B from immediate
        logic oprc_rs2;   // C from rs2, store data
        logic oprc_pcim;  // C from PC plus immediate, branch target
        logic opr_zero;   // A or B deliberately zero
    } opr_src_t;

    // -------------------------------------------------------------------------
    // Encodings
    // -------------------------------------------------------------------------

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam reg_addr_t TRAP_IACCESS = 5'd1;
    localparam reg_addr_t TRAP_IOPCODE = 5'd2;

    localparam word_t PC_RESET_VALUE = 32'h8000_0000;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

// File: hdl/decode_if.sv
// Decoded instruction fields, driven by the decoder and read by the operand selector and top
`timescale 1ns/100ps

interface decode_if;
    import decode_pkg::*;

    fu_t       fu;      // Functional unit one-hot
    uop_t      uop;     // Micro-op code
    reg_addr_t rd;      // Destination or trap cause
    reg_addr_t rs1;     // Register file read addresses
    reg_addr_t rs2;
    word_t     imm;     // Immediate for operand B
    word_t     imm_pc;  // Immediate added to the PC
    opr_src_t  src;     // Operand source flags
    logic      trap;    // Raise a trap

    modport dec (
        output fu, uop, rd, rs1, rs2, imm, imm_pc, src, trap
    );

    modport opr (
        input imm, imm_pc, src
    );

endinterface

// File: hdl/instr_decoder.sv
// Combinational RV32I decoder, turns one instruction word into unit, micro-op and operand sources
`timescale 1ns/100ps

module instr_decoder (
    input  decode_pkg::word_t i_instr,  // Instruction word from fetch
    input  logic              i_error,  // Fetch error on this word
    decode_if.dec             dec
);
    import decode_pkg::*;

    instr_u     ins;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    uop_t       alu_uop;
    logic [1:0] lsu_width;
    fu_t        fu;
    uop_t       uop;
    opr_src_t   src;
    word_t      imm;
    word_t      imm_pc;
    logic       illegal;
    logic       no_rd;

    assign ins    = i_instr;
    assign funct3 = ins.r.funct3;
    assign funct7 = ins.r.funct7;

    // -------------------------------------------------------------------------
    // Immediates
    // -------------------------------------------------------------------------

    assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
    assign imm_s = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
    assign imm_b = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11, ins.b.imm_10_5,
                    ins.b.imm_4_1, 1'b0};
    assign imm_u = {ins.u.imm_31_12, 12'b0};
    assign imm_j = {{11{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12, ins.j.imm_11,
                    ins.j.imm_10_1, 1'b0};

    // Shared by OP and OP-IMM, SUB only exists in the register form
    always_comb begin
        case (funct3)
            3'b000:  alu_uop = (funct7[5] && ins.r.opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_uop = ALU_SLL;
            3'b010:  alu_uop = ALU_SLT;
            3'b011:  alu_uop = ALU_SLTU;
            3'b100:  alu_uop = ALU_XOR;
            3'b101:  alu_uop = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_uop = ALU_OR;
            default: alu_uop = ALU_AND;
        endcase
    end

    assign lsu_width = funct3[1] ? LSU_WORD : (funct3[0] ? LSU_HALF : LSU_BYTE);

    // -------------------------------------------------------------------------
    // Opcode decode
    // -------------------------------------------------------------------------

    always_comb begin
        fu      = '0;
        uop     = '0;
        src     = '0;
        imm     = '0;
        imm_pc  = '0;
        illegal = 1'b0;
        no_rd   = 1'b0;
        case (ins.r.opcode)
            OPC_OP: begin
                fu[FU_ALU]   = 1'b1;
                uop          = alu_uop;
                src.opra_rs1 = 1'b1;
                src.oprb_rs2 = 1'b1;
                illegal      = !(funct7 == 7'h00 ||
                                 (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_OPIMM: begin
                fu[FU_ALU]   = 1'b1;
                uop          = alu_uop;
                src.opra_rs1 = 1'b1;
                src.oprb_imm = 1'b1;
                if (funct3[1:0] == 2'b01) begin
                    imm     = {27'b0, ins.r.rs2};  // Shift amount
                    illegal = funct7 != 7'h00 && !(funct3[2] && funct7 == 7'h20);
                end else begin
                    imm     = imm_i;
                end
            end
            OPC_LUI: begin
                fu[FU_ALU]   = 1'b1;
                uop          = ALU_OR;
                src.oprb_imm = 1'b1;
                src.opr_zero = 1'b1;
                imm          = imm_u;
            end
            OPC_AUIPC: begin
                fu[FU_ALU]    = 1'b1;
                uop           = ALU_ADD;
                src.opra_pcim = 1'b1;
                src.opr_zero  = 1'b1;
                imm           = imm_u;
                imm_pc        = imm_u;
            end
            OPC_LOAD: begin
                fu[FU_LSU]                 = 1'b1;
                uop[LSU_LOAD]              = 1'b1;
                uop[LSU_SIGNED]            = !funct3[2];
                uop[LSU_WIDTH_LSB +: 2]    = lsu_width;
                src.opra_rs1               = 1'b1;
                src.oprb_imm               = 1'b1;
                imm                        = imm_i;
                illegal = funct3[1:0] == 2'b11 || funct3 == 3'b110;
            end
            OPC_STORE: begin
                fu[FU_LSU]              = 1'b1;
                uop[LSU_STORE]          = 1'b1;
                uop[LSU_WIDTH_LSB +: 2] = lsu_width;
                src.opra_rs1            = 1'b1;
                src.oprb_imm            = 1'b1;
                src.oprc_rs2            = 1'b1;
                imm                     = imm_s;
                no_rd                   = 1'b1;
                illegal = funct3[2] || funct3[1:0] == 2'b11;
            end
            OPC_BRANCH: begin
                fu[FU_CFU]    = 1'b1;
                src.opra_rs1  = 1'b1;
                src.oprb_rs2  = 1'b1;
                src.oprc_pcim = 1'b1;
                imm           = imm_b;
                imm_pc        = imm_b;
                no_rd         = 1'b1;
                case (funct3)
                    3'b000:  uop = CFU_BEQ;
                    3'b001:  uop = CFU_BNE;
                    3'b100:  uop = CFU_BLT;
                    3'b101:  uop = CFU_BGE;
                    3'b110:  uop = CFU_BLTU;
                    3'b111:  uop = CFU_BGEU;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_JAL: begin
                fu[FU_CFU]    = 1'b1;
                uop           = CFU_JALI;
                src.oprc_pcim = 1'b1;
                src.opr_zero  = 1'b1;
                imm           = imm_j;
                imm_pc        = imm_j;
            end
            OPC_JALR: begin
                fu[FU_CFU]   = 1'b1;
                uop          = CFU_JALR;
                src.opra_rs1 = 1'b1;
                src.oprb_imm = 1'b1;
                imm          = imm_i;
                illegal      = funct3 != 3'b000;
            end
            OPC_SYSTEM: begin
                fu[FU_CFU] = 1'b1;
                no_rd      = 1'b1;
                if (i_instr == 32'h0000_0073) begin
                    uop = CFU_ECALL;
                end else if (i_instr == 32'h0010_0073) begin
                    uop = CFU_EBREAK;
                end else begin
                    illegal = 1'b1;  // CSR access not supported
                end
            end
            default: illegal = 1'b1;
        endcase
    end

    // -------------------------------------------------------------------------
    // Outputs
    // -------------------------------------------------------------------------

    assign dec.fu     = illegal ? '0 : fu;
    assign dec.uop    = illegal ? '0 : uop;
    assign dec.src    = illegal ? '0 : src;
    assign dec.imm    = illegal ? '0 : imm;
    assign dec.imm_pc = illegal ? '0 : imm_pc;
    assign dec.rs1    = ins.r.rs1;
    assign dec.rs2    = ins.r.rs2;
    assign dec.trap   = illegal || i_error;

    // Trap cause travels in rd, illegal opcode beats fetch error
    assign dec.rd = illegal ? TRAP_IOPCODE :
                    i_error ? TRAP_IACCESS :
                    no_rd   ? '0           : ins.r.rd;

    // One unit per decoded word, no unit only with the illegal-opcode cause
    always_comb begin
        assert ($onehot0(dec.fu) &&
                ((dec.fu == '0) == (dec.trap && dec.rd == TRAP_IOPCODE)))
            else $error("decoder unit select disagrees with the trap cause");
    end

endmodule

// File: hdl/operand_select.sv
// Program counter and operand A, B and C multiplexers, fed by the decoder and the register file
`timescale 1ns/100ps

module operand_select (
    input  logic              g_clk,
    input  logic              g_resetn,
    decode_if.opr             opr,          // Immediates and source flags
    input  decode_pkg::word_t i_rs1_rdata,  // Register file data, same cycle
    input  decode_pkg::word_t i_rs2_rdata,
    input  logic              i_accept,     // Instruction taken this edge
    input  logic              i_cf_load,    // Redirect the PC
    input  decode_pkg::word_t i_cf_target,
    output decode_pkg::word_t o_opr_a,
    output decode_pkg::word_t o_opr_b,
    output decode_pkg::word_t o_opr_c
);
    import decode_pkg::*;

    word_t pc_q;
    word_t pc_imm;
    logic  a_sourced;
    logic  b_sourced;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= PC_RESET_VALUE;
        end else if (i_cf_load) begin
            pc_q <= i_cf_target;    // Redirect wins over advance
        end else if (i_accept) begin
            pc_q <= pc_q + 32'd4;   // RV32I only, fixed 4-byte step
        end
    end

    assign pc_imm = pc_q + opr.imm_pc;

    // -------------------------------------------------------------------------
    // Operand multiplexers, unsourced operands read as zero
    // -------------------------------------------------------------------------

    assign a_sourced = opr.src.opra_rs1 || opr.src.opra_pcim;
    assign b_sourced = opr.src.oprb_rs2 || opr.src.oprb_imm;

    assign o_opr_a = opr.src.opra_rs1  ? i_rs1_rdata :
                     opr.src.opra_pcim ? pc_imm      : '0;

    assign o_opr_b = opr.src.oprb_rs2  ? i_rs2_rdata :
                     opr.src.oprb_imm  ? opr.imm     : '0;

    assign o_opr_c = opr.src.oprc_rs2  ? i_rs2_rdata :  // Store data
                     opr.src.oprc_pcim ? pc_imm      : '0;  // Branch or jump target

    // Decoder flags zero only where A or B really has no source
    zero_src_check: assert property (@(posedge g_clk) disable iff (!g_resetn)
        opr.src.opr_zero |-> !(a_sourced && b_sourced));

endmodule

// File: hdl/decode_pipe_reg.sv
// Decode-to-execute pipeline register with valid/busy handshake, flush and bubble insertion
`timescale 1ns/100ps

module decode_pipe_reg (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  i_valid,   // New instruction offered
    input  logic                  i_bubble,  // Load an empty entry instead
    input  logic                  i_flush,   // Drop the held entry
    input  logic                  i_busy,    // Next stage cannot take data
    output logic                  o_busy,
    output logic                  o_valid,
    input  decode_pkg::fu_t       i_fu,
    input  decode_pkg::uop_t      i_uop,
    input  decode_pkg::reg_addr_t i_rd,
    input  logic                  i_trap,
    input  decode_pkg::word_t     i_opr_a,
    input  decode_pkg::word_t     i_opr_b,
    input  decode_pkg::word_t     i_opr_c,
    output decode_pkg::fu_t       o_fu,
    output decode_pkg::uop_t      o_uop,
    output decode_pkg::reg_addr_t o_rd,
    output logic                  o_trap,
    output decode_pkg::word_t     o_opr_a,
    output decode_pkg::word_t     o_opr_b,
    output decode_pkg::word_t     o_opr_c
);

    logic stall;

    assign stall  = o_valid && i_busy;
    assign o_busy = stall || i_bubble;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
        end else if (!stall) begin
            o_valid <= i_valid || i_bubble;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!stall) begin
            o_fu    <= i_bubble ? '0 : i_fu;
            o_uop   <= i_bubble ? '0 : i_uop;
            o_rd    <= i_bubble ? '0 : i_rd;
            o_trap  <= i_bubble ? 1'b0 : i_trap;
            o_opr_a <= i_bubble ? '0 : i_opr_a;
            o_opr_b <= i_bubble ? '0 : i_opr_b;
            o_opr_c <= i_bubble ? '0 : i_opr_c;
        end
    end

    // Held entry must not change or vanish while the next stage is busy, unless flushed
    stall_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        stall |=> $stable({o_fu, o_uop, o_rd, o_trap, o_opr_a, o_opr_b, o_opr_c}) &&
                  (o_valid || $past(i_flush)));

endmodule

// File: hdl/decode_stage.sv
// RV32I decode stage top, connects decoder, operand selector and pipeline register to plain ports
`timescale 1ns/100ps

module decode_stage (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  i_s1_valid,      // Fetch offers a word
    output logic                  o_s1_busy,       // Stage cannot accept
    input  decode_pkg::word_t     i_s1_data,       // Instruction word
    input  logic                  i_s1_error,      // Fetch error on the word
    input  logic                  i_s1_flush,
    input  logic                  i_s1_bubble,
    output decode_pkg::reg_addr_t o_s1_rs1_addr,   // Register file read ports
    output decode_pkg::reg_addr_t o_s1_rs2_addr,
    input  decode_pkg::word_t     i_s1_rs1_rdata,
    input  decode_pkg::word_t     i_s1_rs2_rdata,
    input  logic                  i_cf_load,       // Control flow redirect
    input  decode_pkg::word_t     i_cf_target,
    output logic                  o_s2_valid,
    input  logic                  i_s2_busy,
    output decode_pkg::reg_addr_t o_s2_rd,         // Destination or trap cause
    output decode_pkg::word_t     o_s2_opr_a,
    output decode_pkg::word_t     o_s2_opr_b,
    output decode_pkg::word_t     o_s2_opr_c,
    output decode_pkg::uop_t      o_s2_uop,
    output decode_pkg::fu_t       o_s2_fu,
    output logic                  o_s2_trap
);
    import decode_pkg::*;

    logic  s1_accept;
    word_t opr_a;
    word_t opr_b;
    word_t opr_c;

    decode_if dec_bus ();

    assign s1_accept     = i_s1_valid && !o_s1_busy;
    assign o_s1_rs1_addr = dec_bus.rs1;
    assign o_s1_rs2_addr = dec_bus.rs2;

    instr_decoder u_decoder (
        .i_instr (i_s1_data),
        .i_error (i_s1_error),
        .dec     (dec_bus.dec)
    );

    operand_select u_opr_sel (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .opr         (dec_bus.opr),
        .i_rs1_rdata (i_s1_rs1_rdata),
        .i_rs2_rdata (i_s1_rs2_rdata),
        .i_accept    (s1_accept),
        .i_cf_load   (i_cf_load),
        .i_cf_target (i_cf_target),
        .o_opr_a     (opr_a),
        .o_opr_b     (opr_b),
        .o_opr_c     (opr_c)
    );

    decode_pipe_reg u_pipe_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_valid  (i_s1_valid),
        .i_bubble (i_s1_bubble),
        .i_flush  (i_s1_flush),
        .i_busy   (i_s2_busy),
        .o_busy   (o_s1_busy),
        .o_valid  (o_s2_valid),
        .i_fu     (dec_bus.fu),
        .i_uop    (dec_bus.uop),
        .i_rd     (dec_bus.rd),
        .i_trap   (dec_bus.trap),
        .i_opr_a  (opr_a),
        .i_opr_b  (opr_b),
        .i_opr_c  (opr_c),
        .o_fu     (o_s2_fu),
        .o_uop    (o_s2_uop),
        .o_rd     (o_s2_rd),
        .o_trap   (o_s2_trap),
        .o_opr_a  (o_s2_opr_a),
        .o_opr_b  (o_s2_opr_b),
        .o_opr_c  (o_s2_opr_c)
    );

endmodule

// File: dv/tb_vectors.svh
// Instruction table for the decode stage testbench, included inside the testbench module
// Columns: instr, fetch error, fu, uop, rd, trap, A source, B source, C source, immediate

localparam int NUM_VEC = 20;

vec_t vectors [NUM_VEC] = '{
    '{32'h002081B3, 1'b0, 3'b001, 5'd1,  5'd3,  1'b0, SEL_RS1,  SEL_RS2,  SEL_ZERO, 32'h0},
    '{32'h407302B3, 1'b0, 3'b001, 5'd2,  5'd5,  1'b0, SEL_RS1,  SEL_RS2,  SEL_ZERO, 32'h0},
    '{32'hFFF08213, 1'b0, 3'b001, 5'd1,  5'd4,  1'b0, SEL_RS1,  SEL_IMM,  SEL_ZERO, 32'hFFFFFFFF},
    '{32'h40315493, 1'b0, 3'b001, 5'd8,  5'd9,  1'b0, SEL_RS1,  SEL_IMM,  SEL_ZERO, 32'h3},
    '{32'h12345537, 1'b0, 3'b001, 5'd4,  5'd10, 1'b0, SEL_ZERO, SEL_IMM,  SEL_ZERO, 32'h12345000},
    '{32'h00001597, 1'b0, 3'b001, 5'd1,  5'd11, 1'b0, SEL_PCIM, SEL_ZERO, SEL_ZERO, 32'h1000},
    '{32'h00418603, 1'b0, 3'b010, 5'd11, 5'd12, 1'b0, SEL_RS1,  SEL_IMM,  SEL_ZERO, 32'h4},
    '{32'hFFE25683, 1'b0, 3'b010, 5'd12, 5'd13, 1'b0, SEL_RS1,  SEL_IMM,  SEL_ZERO, 32'hFFFFFFFE},
    '{32'h0082A703, 1'b0, 3'b010, 5'd15, 5'd14, 1'b0, SEL_RS1,  SEL_IMM,  SEL_ZERO, 32'h8},
    '{32'h0063A623, 1'b0, 3'b010, 5'd22, 5'd0,  1'b0, SEL_RS1,  SEL_IMM,  SEL_RS2,  32'hC},
    '{32'hFE848FA3, 1'b0, 3'b010, 5'd18, 5'd0,  1'b0, SEL_RS1,  SEL_IMM,  SEL_RS2,  32'hFFFFFFFF},
    '{32'h00208863, 1'b0, 3'b100, 5'd1,  5'd0,  1'b0, SEL_RS1,  SEL_RS2,  SEL_PCIM, 32'h10},
    '{32'hFE419CE3, 1'b0, 3'b100, 5'd2,  5'd0,  1'b0, SEL_RS1,  SEL_RS2,  SEL_PCIM, 32'hFFFFFFF8},
    '{32'h001000EF, 1'b0, 3'b100, 5'd7,  5'd1,  1'b0, SEL_ZERO, SEL_ZERO, SEL_PCIM, 32'h800},
    '{32'h00008067, 1'b0, 3'b100, 5'd8,  5'd0,  1'b0, SEL_RS1,  SEL_IMM,  SEL_ZERO, 32'h0},
    '{32'h00000073, 1'b0, 3'b100, 5'd9,  5'd0,  1'b0, SEL_ZERO, SEL_ZERO, SEL_ZERO, 32'h0},
    '{32'h00100073, 1'b0, 3'b100, 5'd10, 5'd0,  1'b0, SEL_ZERO, SEL_ZERO, SEL_ZERO, 32'h0},
    '{32'hFFFFFFFF, 1'b0, 3'b000, 5'd0,  5'd2,  1'b1, SEL_ZERO, SEL_ZERO, SEL_ZERO, 32'h0},
    '{32'h002081B3, 1'b1, 3'b001, 5'd1,  5'd1,  1'b1, SEL_RS1,  SEL_RS2,  SEL_ZERO, 32'h0},
    '{32'h0000007F, 1'b1, 3'b000, 5'd0,  5'd2,  1'b1, SEL_ZERO, SEL_ZERO, SEL_ZERO, 32'h0}
};

// File: dv/tb_decode_stage.sv
// Testbench for the decode stage, runs the instruction table under random back-pressure
`timescale 1ns/100ps

module tb_decode_stage;
    import decode_pkg::*;

    localparam logic [2:0] SEL_ZERO = 3'd0;
    localparam logic [2:0] SEL_RS1  = 3'd1;
    localparam logic [2:0] SEL_RS2  = 3'd2;
    localparam logic [2:0] SEL_IMM  = 3'd3;
    localparam logic [2:0] SEL_PCIM = 3'd4;

    localparam int BUSY_RAND = 0;
    localparam int BUSY_LOW  = 1;
    localparam int BUSY_HIGH = 2;

    typedef struct packed {
        word_t      instr;
        logic       err;
        fu_t        fu;
        uop_t       uop;
        reg_addr_t  rd;
        logic       trap;
        logic [2:0] a_sel;
        logic [2:0] b_sel;
        logic [2:0] c_sel;
        word_t      imm;
    } vec_t;

    typedef struct packed {
        fu_t       fu;
        uop_t      uop;
        reg_addr_t rd;
        logic      trap;
        word_t     a;
        word_t     b;
        word_t     c;
    } exp_t;

    `include "tb_vectors.svh"

    localparam int TIMEOUT_CYCLES = NUM_VEC * 8 + 100;

    logic      g_clk;
    logic      g_resetn;
    logic      i_s1_valid;
    logic      o_s1_busy;
    word_t     i_s1_data;
    logic      i_s1_error;
    logic      i_s1_flush;
    logic      i_s1_bubble;
    reg_addr_t o_s1_rs1_addr;
    reg_addr_t o_s1_rs2_addr;
    word_t     i_s1_rs1_rdata;
    word_t     i_s1_rs2_rdata;
    logic      i_cf_load;
    word_t     i_cf_target;
    logic      o_s2_valid;
    logic      i_s2_busy;
    reg_addr_t o_s2_rd;
    word_t     o_s2_opr_a;
    word_t     o_s2_opr_b;
    word_t     o_s2_opr_c;
    uop_t      o_s2_uop;
    fu_t       o_s2_fu;
    logic      o_s2_trap;

    exp_t  exp_q[$];           // Entries expected at the stage output, oldest first
    word_t pc_model;
    int    cycle_count = 0;
    bit    accepted;

    decode_stage uut (.*);

    function automatic word_t rf_value(reg_addr_t addr);
        return ({27'b0, addr} * 32'h0101_0101) ^ 32'hA5A5_0000;
    endfunction

    assign i_s1_rs1_rdata = rf_value(o_s1_rs1_addr);  // Register file answers at once
    assign i_s1_rs2_rdata = rf_value(o_s1_rs2_addr);

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    always @(posedge g_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_fu(string name, fu_t got, fu_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_uop(string name, uop_t got, uop_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_rd(string name, reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_entry(exp_t e);
        check_fu("o_s2_fu", o_s2_fu, e.fu);
        check_uop("o_s2_uop", o_s2_uop, e.uop);
        check_rd("o_s2_rd", o_s2_rd, e.rd);
        check_bit("o_s2_trap", o_s2_trap, e.trap);
        check_word("o_s2_opr_a", o_s2_opr_a, e.a);
        check_word("o_s2_opr_b", o_s2_opr_b, e.b);
        check_word("o_s2_opr_c", o_s2_opr_c, e.c);
    endtask

    // ------------------------------------------------------------------------
    // Expected values from the table and the PC model
    // ------------------------------------------------------------------------

    function automatic word_t operand_value(logic [2:0] sel, int idx, word_t pc);
        case (sel)
            SEL_RS1:  return rf_value(vectors[idx].instr[19:15]);
            SEL_RS2:  return rf_value(vectors[idx].instr[24:20]);
            SEL_IMM:  return vectors[idx].imm;
            SEL_PCIM: return pc + vectors[idx].imm;
            default:  return '0;
        endcase
    endfunction

    function automatic exp_t expected_entry(int idx, word_t pc);
        exp_t e;
        e.fu   = vectors[idx].fu;
        e.uop  = vectors[idx].uop;
        e.rd   = vectors[idx].rd;
        e.trap = vectors[idx].trap;
        e.a    = operand_value(vectors[idx].a_sel, idx, pc);
        e.b    = operand_value(vectors[idx].b_sel, idx, pc);
        e.c    = operand_value(vectors[idx].c_sel, idx, pc);
        return e;
    endfunction

    // One clock cycle: check the held output, drive inputs, track what the edge does
    task automatic run_cycle(input bit valid, input int idx, input bit bubble, input bit flush,
                             input bit cf_load, input word_t target, input int busy_mode,
                             output bit taken);
        bit stalled;
        bit exp_busy;
        @(negedge g_clk);
        check_bit("o_s2_valid", o_s2_valid, exp_q.size() != 0);
        if (o_s2_valid) begin
            compare_entry(exp_q[0]);
        end
        case (busy_mode)
            BUSY_LOW:  i_s2_busy = 1'b0;
            BUSY_HIGH: i_s2_busy = 1'b1;
            default:   i_s2_busy = ($urandom & 3) == 0;
        endcase
        i_s1_valid  = valid;
        i_s1_data   = (idx >= 0) ? vectors[idx].instr : '0;
        i_s1_error  = (idx >= 0) ? vectors[idx].err : 1'b0;
        i_s1_bubble = bubble;
        i_s1_flush  = flush;
        i_cf_load   = cf_load;
        i_cf_target = target;
        #1;
        stalled  = exp_q.size() != 0 && i_s2_busy;  // Held entry cannot leave
        exp_busy = stalled || bubble;
        check_bit("o_s1_busy", o_s1_busy, exp_busy);
        taken    = valid && !exp_busy;
        if (exp_q.size() != 0 && (!i_s2_busy || flush)) begin
            void'(exp_q.pop_front());  // Consumed or dropped at this edge
        end
        if (bubble && !stalled) begin
            exp_q.push_back('0);
        end
        if (taken) begin
            exp_q.push_back(expected_entry(idx, pc_model));
        end
        if (cf_load) begin
            pc_model = target;
        end else if (taken) begin
            pc_model = pc_model + 32'd4;
        end
    endtask

    task automatic apply_entry(int idx);
        bit taken;
        taken = 1'b0;
        while (!taken) begin
            run_cycle(1'b1, idx, 1'b0, 1'b0, 1'b0, '0, BUSY_RAND, taken);
        end
    endtask

    task automatic drain_output();
        bit taken;
        do begin
            run_cycle(1'b0, -1, 1'b0, 1'b0, 1'b0, '0, BUSY_RAND, taken);
        end while (exp_q.size() != 0 || o_s2_valid);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        void'($urandom(32'h4678));
        g_resetn    = 1'b0;
        i_s1_valid  = 1'b0;
        i_s1_data   = '0;
        i_s1_error  = 1'b0;
        i_s1_flush  = 1'b0;
        i_s1_bubble = 1'b0;
        i_cf_load   = 1'b0;
        i_cf_target = '0;
        i_s2_busy   = 1'b0;
        pc_model    = 32'h8000_0000;
        repeat (16) @(negedge g_clk);
        g_resetn = 1'b1;
        check_bit("o_s2_valid", o_s2_valid, 1'b0);

        for (int i = 0; i < NUM_VEC; i++) begin
            apply_entry(i);
        end
        drain_output();

        run_cycle(1'b0, -1, 1'b1, 1'b0, 1'b0, '0, BUSY_LOW, accepted);  // Bubble
        drain_output();

        // Held entry is dropped by the flush
        run_cycle(1'b1, 2, 1'b0, 1'b0, 1'b0, '0, BUSY_HIGH, accepted);
        run_cycle(1'b0, -1, 1'b0, 1'b1, 1'b0, '0, BUSY_HIGH, accepted);
        run_cycle(1'b0, -1, 1'b0, 1'b0, 1'b0, '0, BUSY_LOW, accepted);
        check_bit("o_s2_valid", o_s2_valid, 1'b0);

        // Redirect on the same edge as an accepted AUIPC
        run_cycle(1'b1, 5, 1'b0, 1'b0, 1'b1, 32'h0000_1000, BUSY_LOW, accepted);
        apply_entry(5);  // AUIPC after the redirect
        drain_output();

        if (exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("Entries were still expected when the run ended");
            stop_with_failure();
        end
    end

endmodule

// File: compile.f
hdl/decode_pkg.sv
hdl/decode_if.sv
hdl/instr_decoder.sv
hdl/operand_select.sv
hdl/decode_pipe_reg.sv
hdl/decode_stage.sv
+incdir+dv
dv/tb_decode_stage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_decode_stage
FILELIST  = compile.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the decode stage testbench with Verilator"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
